// File: source/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// ######################################################################
// memory geometry
// ######################################################################

// size of the shared memory in bytes, kept a power of two
`define MEM_SIZE 1024

// byte address width, log2 of the memory size
`define ADDR_WIDTH 10

// width of one word on both ports
`define DATA_WIDTH 32

// number of register stages in the memory pipeline
`define MEM_DEPTH 10

`endif

// File: source/mem_req_pkg.sv
`include "mem_params.svh"

package mem_req_pkg;

  // ######################################################################
  // memory access description
  // ######################################################################

  // width of a single access
  typedef enum logic {
    BYTE = 1'b0,
    WORD = 1'b1
  } access_size_t;

  // request as presented by a port
  // wdata is only meaningful for writes, and a byte write uses wdata[7:0]
  typedef struct packed {
    logic                   valid;
    logic                   write;
    access_size_t           size;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0] wdata;
  } mem_req_t;

endpackage

// File: source/port_pkg.sv
`include "mem_params.svh"

package port_pkg;

  // ######################################################################
  // requesters and returns
  // ######################################################################

  // which side of the core issued a request
  typedef enum logic {
    PORT_FETCH = 1'b0,
    PORT_DATA  = 1'b1
  } port_id_t;

  // granted request with its origin, from the arbiter into the pipeline
  typedef struct packed {
    mem_req_pkg::mem_req_t req;
    port_id_t              port;
  } tagged_req_t;

  // read result leaving the pipeline
  // rdata holds the bytes at addr to addr+3, least significant first
  typedef struct packed {
    logic                      valid;
    port_id_t                  port;
    mem_req_pkg::access_size_t size;
    logic [`DATA_WIDTH-1:0]    rdata;
  } raw_rsp_t;

  // response returned to one port
  typedef struct packed {
    logic                   valid;
    logic [`DATA_WIDTH-1:0] data;
  } port_rsp_t;

endpackage

// File: source/port_arbiter.sv
`timescale 1ns/10ps

module port_arbiter (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  mem_req_pkg::mem_req_t    fetch_req_i,
  input  mem_req_pkg::mem_req_t    data_req_i,
  output logic                     fetch_ready_o,
  output logic                     data_ready_o,
  output port_pkg::tagged_req_t    grant_o
);

  // port that won the most recent contested cycle
  port_pkg::port_id_t last_q;

  logic contested;
  logic sel_data;

  assign contested = fetch_req_i.valid && data_req_i.valid;

  // a port only loses its ready when both ask and it won last time
  assign fetch_ready_o = !contested || (last_q == port_pkg::PORT_DATA);
  assign data_ready_o  = !contested || (last_q == port_pkg::PORT_FETCH);

  assign sel_data = data_req_i.valid && data_ready_o;

  always_comb begin
    if (sel_data) begin
      grant_o.req  = data_req_i;
      grant_o.port = port_pkg::PORT_DATA;
    end else begin
      // the fetch side is read-only, so any write bit is dropped here
      grant_o.req       = fetch_req_i;
      grant_o.req.write = 1'b0;
      grant_o.port      = port_pkg::PORT_FETCH;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      // data port takes the first tie
      last_q <= port_pkg::PORT_FETCH;
    end else if (contested) begin
      last_q <= sel_data ? port_pkg::PORT_DATA : port_pkg::PORT_FETCH;
    end
  end

  // ######################################################################
  // checks
  // ######################################################################

  // only one port may be accepted in a cycle
  assert property (@(posedge clk_i) disable iff (!rst_i)
    contested |-> !(fetch_ready_o && data_ready_o))
    else $error("port_arbiter: both ports ready while both request");

  // two contested cycles in a row go to different ports
  assert property (@(posedge clk_i) disable iff (!rst_i)
    (contested ##1 contested) |-> (grant_o.port != $past(grant_o.port)))
    else $error("port_arbiter: round robin did not alternate");

endmodule

// File: source/mem_pipeline.sv
`timescale 1ns/10ps

`include "mem_params.svh"

module mem_pipeline (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  port_pkg::tagged_req_t req_i,
  output port_pkg::raw_rsp_t    rsp_o
);

  // index of stage 5, where the array is read or written
  localparam int ACCESS_STAGE = 4;
  localparam int WORD_BYTES   = `DATA_WIDTH / 8;

  logic [7:0] mem [`MEM_SIZE] = '{default: 8'h00};

  // stage_q[0] is stage 1 and holds the request accepted on the last edge
  port_pkg::tagged_req_t stage_q [`MEM_DEPTH];

  port_pkg::tagged_req_t acc;
  port_pkg::tagged_req_t acc_out;

  logic [`ADDR_WIDTH-1:0] byte_addr [WORD_BYTES];
  logic [`DATA_WIDTH-1:0] rd_word;

  assign acc = stage_q[ACCESS_STAGE];

  // ######################################################################
  // access stage
  // ######################################################################

  // addresses are kept at ADDR_WIDTH bits so a word wraps at the top of memory
  always_comb begin
    for (int b = 0; b < WORD_BYTES; b++) begin
      byte_addr[b] = acc.req.addr + `ADDR_WIDTH'(b);
    end
  end

  // always read a full word, the router trims byte reads
  always_comb begin
    for (int b = 0; b < WORD_BYTES; b++) begin
      rd_word[8*b +: 8] = mem[byte_addr[b]];
    end
  end

  // after the access stage the wdata field carries the read data instead
  always_comb begin
    acc_out           = acc;
    acc_out.req.wdata = rd_word;
    if (acc.req.write) begin
      acc_out.req.valid = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc.req.valid && acc.req.write) begin
      mem[byte_addr[0]] <= acc.req.wdata[7:0];
      if (acc.req.size == mem_req_pkg::WORD) begin
        for (int b = 1; b < WORD_BYTES; b++) begin
          mem[byte_addr[b]] <= acc.req.wdata[8*b +: 8];
        end
      end
    end
  end

  // ######################################################################
  // stage registers
  // ######################################################################

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < `MEM_DEPTH; i++) begin
        stage_q[i].req.valid <= 1'b0;
      end
    end else begin
      stage_q[0] <= req_i;
      for (int i = 1; i < `MEM_DEPTH; i++) begin
        if (i == ACCESS_STAGE + 1) begin
          stage_q[i] <= acc_out;
        end else begin
          stage_q[i] <= stage_q[i-1];
        end
      end
    end
  end

  // reads leave the last stage ten cycles after acceptance
  assign rsp_o.valid = stage_q[`MEM_DEPTH-1].req.valid;
  assign rsp_o.port  = stage_q[`MEM_DEPTH-1].port;
  assign rsp_o.size  = stage_q[`MEM_DEPTH-1].req.size;
  assign rsp_o.rdata = stage_q[`MEM_DEPTH-1].req.wdata;

  // ######################################################################
  // checks
  // ######################################################################

  // an unknown valid would poison every stage behind it
  assert property (@(posedge clk_i) disable iff (!rst_i)
    !$isunknown(req_i.req.valid))
    else $error("mem_pipeline: request valid is unknown");

  // a read entering stage 1 comes out of the last stage MEM_DEPTH cycles later
  assert property (@(posedge clk_i) disable iff (!rst_i)
    (req_i.req.valid && !req_i.req.write) |-> ##`MEM_DEPTH rsp_o.valid)
    else $error("mem_pipeline: read lost in the pipeline");

endmodule

// File: source/rsp_router.sv
`timescale 1ns/10ps

`include "mem_params.svh"

module rsp_router (
  input  logic                clk_i,
  input  logic                rst_i,
  input  port_pkg::raw_rsp_t  rsp_i,
  output port_pkg::port_rsp_t fetch_rsp_o,
  output port_pkg::port_rsp_t data_rsp_o
);

  logic [`DATA_WIDTH-1:0] ext_data;
  logic                   to_fetch;
  logic                   to_data;

  // byte reads return the low byte with the upper bits cleared
  always_comb begin
    if (rsp_i.size == mem_req_pkg::BYTE) begin
      ext_data = {{(`DATA_WIDTH-8){1'b0}}, rsp_i.rdata[7:0]};
    end else begin
      ext_data = rsp_i.rdata;
    end
  end

  assign to_fetch = rsp_i.valid && (rsp_i.port == port_pkg::PORT_FETCH);
  assign to_data  = rsp_i.valid && (rsp_i.port == port_pkg::PORT_DATA);

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      fetch_rsp_o.valid <= 1'b0;
      data_rsp_o.valid  <= 1'b0;
    end else begin
      fetch_rsp_o.valid <= to_fetch;
      data_rsp_o.valid  <= to_data;
    end
  end

  // data lines only move when their port gets a result
  always_ff @(posedge clk_i) begin
    if (to_fetch) begin
      fetch_rsp_o.data <= ext_data;
    end
    if (to_data) begin
      data_rsp_o.data <= ext_data;
    end
  end

  // each raw response shows up on exactly one port one cycle later
  assert property (@(posedge clk_i) disable iff (!rst_i)
    rsp_i.valid |=> $onehot({fetch_rsp_o.valid, data_rsp_o.valid}))
    else $error("rsp_router: response not routed to a single port");

endmodule

// File: source/mem_subsystem.sv
`timescale 1ns/10ps

module mem_subsystem (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  mem_req_pkg::mem_req_t fetch_req_i,
  input  mem_req_pkg::mem_req_t data_req_i,
  output logic                  fetch_ready_o,
  output logic                  data_ready_o,
  output port_pkg::port_rsp_t   fetch_rsp_o,
  output port_pkg::port_rsp_t   data_rsp_o
);

  port_pkg::tagged_req_t grant;
  port_pkg::raw_rsp_t    raw_rsp;

  // input side, one request per cycle
  port_arbiter u_port_arbiter (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fetch_req_i   (fetch_req_i),
    .data_req_i    (data_req_i),
    .fetch_ready_o (fetch_ready_o),
    .data_ready_o  (data_ready_o),
    .grant_o       (grant)
  );

  mem_pipeline u_mem_pipeline (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (grant),
    .rsp_o (raw_rsp)
  );

  // output side, results back to the port that asked
  rsp_router u_rsp_router (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rsp_i       (raw_rsp),
    .fetch_rsp_o (fetch_rsp_o),
    .data_rsp_o  (data_rsp_o)
  );

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
  output logic clk_o,
  output logic rst_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // active low reset, released just after the eighth rising edge
  initial begin
    rst_o = 1'b0;
    repeat (8) @(posedge clk_o);
    #1 rst_o = 1'b1;
  end

endmodule

// File: bench/mem_subsystem_tb.sv
`timescale 1ns/10ps

`include "mem_params.svh"

module mem_subsystem_tb;

  localparam int CLK_NS      = 4;
  localparam int LATENCY     = 11;
  localparam int RAND_N      = 200;
  // the directed tests issue 37 requests and the random test RAND_N per port
  localparam int TOTAL_REQS  = 37 + 2 * RAND_N;
  localparam int WATCHDOG_NS = TOTAL_REQS * CLK_NS + 1000;

  typedef struct packed {
    logic [`DATA_WIDTH-1:0] data;
    int                     due;
  } expect_t;

  logic                  clk;
  logic                  rst;
  mem_req_pkg::mem_req_t fetch_req;
  mem_req_pkg::mem_req_t data_req;
  logic                  fetch_ready;
  logic                  data_ready;
  port_pkg::port_rsp_t   fetch_rsp;
  port_pkg::port_rsp_t   data_rsp;

  // queues and model state are indexed by port id
  mem_req_pkg::mem_req_t todo_q [2][$];
  expect_t               exp_q [2][$];
  logic [7:0]            model_mem [`MEM_SIZE];
  port_pkg::port_id_t    model_last;
  logic                  fetch_acc;
  logic                  data_acc;
  int                    cycle;
  int                    errors;
  int                    err_base;
  int                    checks;
  int                    tests_run;

  clock_gen u_clock_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  mem_subsystem DUT (
    .clk_i         (clk),
    .rst_i         (rst),
    .fetch_req_i   (fetch_req),
    .data_req_i    (data_req),
    .fetch_ready_o (fetch_ready),
    .data_ready_o  (data_ready),
    .fetch_rsp_o   (fetch_rsp),
    .data_rsp_o    (data_rsp)
  );

  // ####################################################################
  // reference model
  // ####################################################################

  function automatic logic [`DATA_WIDTH-1:0] model_read(input mem_req_pkg::mem_req_t req);
    logic [`DATA_WIDTH-1:0] word;
    for (int b = 0; b < 4; b++) begin
      word[8*b +: 8] = model_mem[req.addr + `ADDR_WIDTH'(b)];
    end
    if (req.size == mem_req_pkg::BYTE) begin
      word[`DATA_WIDTH-1:8] = '0;
    end
    return word;
  endfunction

  task automatic apply_request(input mem_req_pkg::mem_req_t req, input port_pkg::port_id_t port);
    expect_t e;
    // fetch requests always read whatever their write bit says
    if (req.write && port == port_pkg::PORT_DATA) begin
      for (int b = 0; b < 4; b++) begin
        if (b == 0 || req.size == mem_req_pkg::WORD) begin
          model_mem[req.addr + `ADDR_WIDTH'(b)] = req.wdata[8*b +: 8];
        end
      end
    end else begin
      e.data = model_read(req);
      e.due  = cycle + LATENCY;
      exp_q[int'(port)].push_back(e);
    end
  endtask

  task automatic arbitrate_model();
    logic               contested;
    port_pkg::port_id_t winner;
    logic               exp_fetch_ready;
    logic               exp_data_ready;
    contested = fetch_req.valid && data_req.valid;
    // a tie goes to the port that was not granted last
    if (model_last == port_pkg::PORT_FETCH) begin
      winner = port_pkg::PORT_DATA;
    end else begin
      winner = port_pkg::PORT_FETCH;
    end
    exp_fetch_ready = 1'b1;
    exp_data_ready  = 1'b1;
    if (contested) begin
      exp_fetch_ready = (winner == port_pkg::PORT_FETCH);
      exp_data_ready  = (winner == port_pkg::PORT_DATA);
    end
    if (fetch_ready !== exp_fetch_ready) begin
      $display("ERROR fetch_ready_o expected %h got %h", exp_fetch_ready, fetch_ready);
      errors++;
    end
    if (data_ready !== exp_data_ready) begin
      $display("ERROR data_ready_o expected %h got %h", exp_data_ready, data_ready);
      errors++;
    end
    fetch_acc = fetch_req.valid && exp_fetch_ready;
    data_acc  = data_req.valid && exp_data_ready;
    if (contested) begin
      model_last = winner;
    end
  endtask

  task automatic check_port(input port_pkg::port_id_t port, input port_pkg::port_rsp_t rsp,
                            input string name);
    expect_t head;
    int      p;
    p = int'(port);
    if (rsp.valid) begin
      checks++;
      if (exp_q[p].size() == 0) begin
        $display("unexpected response on the %s port at cycle %0d", name, cycle);
        errors++;
      end else begin
        head = exp_q[p].pop_front();
        if (head.due != cycle) begin
          $display("%s response came at cycle %0d, expected at cycle %0d", name, cycle, head.due);
          errors++;
        end
        if (rsp.data !== head.data) begin
          $display("ERROR %s_rsp_o.data expected %08h got %08h", name, head.data, rsp.data);
          errors++;
        end
      end
    end else if (exp_q[p].size() > 0 && exp_q[p][0].due <= cycle) begin
      $display("missing response on the %s port, due at cycle %0d", name, exp_q[p][0].due);
      void'(exp_q[p].pop_front());
      errors++;
    end
  endtask

  // outputs are stable at the falling edge and acceptance happens on the next rising edge
  always @(negedge clk) begin
    if (rst) begin
      cycle++;
      check_port(port_pkg::PORT_FETCH, fetch_rsp, "fetch");
      check_port(port_pkg::PORT_DATA, data_rsp, "data");
      arbitrate_model();
      if (fetch_acc) begin
        apply_request(fetch_req, port_pkg::PORT_FETCH);
      end
      if (data_acc) begin
        apply_request(data_req, port_pkg::PORT_DATA);
      end
    end
  end

  // ####################################################################
  // stimulus
  // ####################################################################

  function automatic mem_req_pkg::mem_req_t next_req(input port_pkg::port_id_t port);
    mem_req_pkg::mem_req_t req;
    req = '0;
    if (todo_q[int'(port)].size() > 0) begin
      req = todo_q[int'(port)].pop_front();
    end
    return req;
  endfunction

  // a request is held until the model says it was accepted
  always @(posedge clk) begin
    #1;
    if (rst) begin
      if (!fetch_req.valid || fetch_acc) begin
        fetch_req = next_req(port_pkg::PORT_FETCH);
      end
      if (!data_req.valid || data_acc) begin
        data_req = next_req(port_pkg::PORT_DATA);
      end
    end
  end

  task automatic push_req(input port_pkg::port_id_t port, input logic write, input logic word,
                          input logic [`ADDR_WIDTH-1:0] addr, input logic [`DATA_WIDTH-1:0] wdata);
    mem_req_pkg::mem_req_t req;
    req.valid = 1'b1;
    req.write = write;
    req.size  = word ? mem_req_pkg::WORD : mem_req_pkg::BYTE;
    req.addr  = addr;
    req.wdata = wdata;
    todo_q[int'(port)].push_back(req);
  endtask

  task automatic finish_test(input string name);
    logic busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      #3;
      busy = fetch_req.valid || data_req.valid || todo_q[0].size() > 0
             || todo_q[1].size() > 0 || exp_q[0].size() > 0 || exp_q[1].size() > 0;
    end
    tests_run++;
    $display("test %0d %s %s, %0d errors", tests_run, name,
             (errors == err_base) ? "ok" : "with errors", errors - err_base);
    err_base = errors;
  endtask

  initial begin
    int          seed_out;
    logic [31:0] rnd;
    seed_out   = $urandom(32'h57db);
    fetch_req  = '0;
    data_req   = '0;
    fetch_acc  = 1'b0;
    data_acc   = 1'b0;
    cycle      = 0;
    errors     = 0;
    err_base   = 0;
    checks     = 0;
    tests_run  = 0;
    model_last = port_pkg::PORT_FETCH;
    for (int i = 0; i < `MEM_SIZE; i++) begin
      model_mem[i] = 8'h00;
    end
    @(posedge rst);
    repeat (2) @(posedge clk);

    // stay quiet after reset and then send one lone request per port
    repeat (20) @(posedge clk);
    push_req(port_pkg::PORT_DATA, 1'b0, 1'b1, 10'h000, '0);
    repeat (3) @(posedge clk);
    push_req(port_pkg::PORT_FETCH, 1'b0, 1'b1, 10'h004, '0);
    finish_test("reset_idle");

    // the word at 3fe wraps into bytes 0 and 1
    push_req(port_pkg::PORT_DATA, 1'b1, 1'b1, 10'h010, 32'h4433_2211);
    push_req(port_pkg::PORT_DATA, 1'b1, 1'b0, 10'h011, 32'h0000_00a5);
    push_req(port_pkg::PORT_DATA, 1'b1, 1'b0, 10'h020, 32'hffff_ff7e);
    push_req(port_pkg::PORT_DATA, 1'b1, 1'b1, 10'h3fe, 32'hddcc_bbaa);
    push_req(port_pkg::PORT_DATA, 1'b0, 1'b1, 10'h010, '0);
    push_req(port_pkg::PORT_DATA, 1'b0, 1'b0, 10'h011, '0);
    push_req(port_pkg::PORT_DATA, 1'b0, 1'b0, 10'h020, '0);
    push_req(port_pkg::PORT_DATA, 1'b0, 1'b1, 10'h3fe, '0);
    push_req(port_pkg::PORT_DATA, 1'b0, 1'b1, 10'h000, '0);
    push_req(port_pkg::PORT_DATA, 1'b0, 1'b0, 10'h013, '0);
    push_req(port_pkg::PORT_DATA, 1'b0, 1'b1, 10'h00f, '0);
    push_req(port_pkg::PORT_DATA, 1'b0, 1'b0, 10'h3ff, '0);
    finish_test("write_read");

    for (int i = 0; i < 4; i++) begin
      push_req(port_pkg::PORT_FETCH, 1'b0, 1'b1, 10'h00e + 10'(i), '0);
    end
    repeat (8) @(posedge clk);
    for (int i = 0; i < 4; i++) begin
      push_req(port_pkg::PORT_DATA, 1'b0, 1'(i), 10'h010 + 10'(i), '0);
    end
    finish_test("latency");

    // this is the first contested cycle of the run so the data port must win it
    for (int i = 0; i < 6; i++) begin
      rnd = $urandom();
      push_req(port_pkg::PORT_FETCH, 1'b0, rnd[0], rnd[11:2], '0);
      push_req(port_pkg::PORT_DATA, 1'b0, rnd[1], rnd[21:12], '0);
    end
    finish_test("arbitration");

    push_req(port_pkg::PORT_FETCH, 1'b1, 1'b1, 10'h040, 32'hdead_beef);
    push_req(port_pkg::PORT_FETCH, 1'b1, 1'b0, 10'h041, 32'h0000_005a);
    repeat (4) @(posedge clk);
    push_req(port_pkg::PORT_DATA, 1'b0, 1'b1, 10'h040, '0);
    finish_test("fetch_write");

    for (int i = 0; i < RAND_N; i++) begin
      rnd = $urandom();
      push_req(port_pkg::PORT_DATA, rnd[1], rnd[0], rnd[11:2], $urandom());
      rnd = $urandom();
      push_req(port_pkg::PORT_FETCH, rnd[1], rnd[0], rnd[11:2], $urandom());
    end
    finish_test("random");

    $display("tests %0d, responses checked %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: flist.f
+incdir+source
source/mem_req_pkg.sv
source/port_pkg.sv
source/port_arbiter.sv
source/mem_pipeline.sv
source/rsp_router.sv
source/mem_subsystem.sv
bench/clock_gen.sv
bench/mem_subsystem_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module mem_subsystem_tb -o sim_bin
	./obj_dir/sim_bin | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
